//--- hdl/iffifo_bus_demux.sv
// Register bus address decoder and response merge for the iffifo targets
`timescale 1ns/1ns

module iffifo_bus_demux (
  input  logic               reg_valid_i,
  input  logic               reg_write_i,
  input  iffifo_pkg::addr_t  reg_addr_i,
  input  iffifo_pkg::data_t  regs_rdata_i,
  input  iffifo_pkg::data_t  win_rdata_i,
  input  logic               regs_error_i,
  input  logic               win_error_i,
  output logic               regs_valid_o,
  output logic               tx_win_valid_o,
  output logic               rx_win_valid_o,
  output iffifo_pkg::data_t  reg_rdata_o,
  output logic               reg_error_o
);

  import iffifo_pkg::*;

  // Address range hits
  logic in_regs;
  logic in_win;

  // All valids come out of one block so they change together
  always_comb begin
    // Register file owns everything below the window
    in_regs = (reg_addr_i < WIN_BASE);
    in_win  = (reg_addr_i >= WIN_BASE) && (reg_addr_i <= WIN_LAST);

    regs_valid_o   = reg_valid_i & in_regs;
    // Window direction picks the FIFO, exact offset is checked downstream
    tx_win_valid_o = reg_valid_i & in_win & reg_write_i;
    rx_win_valid_o = reg_valid_i & in_win & ~reg_write_i;
  end

  // Response merge
  always_comb begin
    reg_rdata_o = '0;
    reg_error_o = 1'b0;
    if (reg_valid_i) begin
      if (in_regs) begin
        reg_rdata_o = regs_rdata_i;
        reg_error_o = regs_error_i;
      end else if (in_win) begin
        // Both windows share one response, only one of them is ever active
        reg_rdata_o = win_rdata_i;
        reg_error_o = win_error_i;
      end else begin
        // Beyond 0x17 nothing answers
        reg_error_o = 1'b1;
      end
    end
  end

endmodule

//--- hdl/iffifo_fifo.sv
// Synchronous first-word-fall-through FIFO with fill level and error pulses
`timescale 1ns/1ns

module iffifo_fifo #(
  parameter int WIDTH = 32,
  // Power of two, at least 2
  parameter int DEPTH = 4
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                push_i,
  input  logic                pop_i,
  input  logic [WIDTH-1:0]    wdata_i,
  output logic [WIDTH-1:0]    rdata_o,
  output logic                full_o,
  output logic                empty_o,
  output iffifo_pkg::level_t  level_o,
  output logic                overflow_o,
  output logic                underflow_o
);

  import iffifo_pkg::*;

  localparam int PW = $clog2(DEPTH);

  // Storage, no reset
  logic [WIDTH-1:0] mem_q [DEPTH];

  // Pointers carry one wrap bit above the index
  logic [PW:0] wr_ptr_q;
  logic [PW:0] rd_ptr_q;
  level_t      level_q;

  // Accepted operations
  logic do_push;
  logic do_pop;

  // Flags from the pointers, the counter runs alongside as the level
  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[PW] != rd_ptr_q[PW]) &&
                   (wr_ptr_q[PW-1:0] == rd_ptr_q[PW-1:0]);

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Rejected requests show up as single-cycle pulses
  assign overflow_o  = push_i & full_o;
  assign underflow_o = pop_i & empty_o;

  // Head word is visible without a pop
  assign rdata_o = mem_q[rd_ptr_q[PW-1:0]];
  assign level_o = level_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the level alone
      if (do_push && !do_pop) begin
        level_q <= level_q + 1'b1;
      end else if (do_pop && !do_push) begin
        level_q <= level_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q[PW-1:0]] <= wdata_i;
    end
  end

  // Counter stays within the storage
  assert property (@(posedge clk_i) disable iff (rst_i) level_q <= level_t'(DEPTH))
    else $error("fifo level above depth");

  // Pointer view and counter view agree on emptiness
  assert property (@(posedge clk_i) disable iff (rst_i) empty_o == (level_q == '0))
    else $error("fifo empty flag disagrees with level");

endmodule

//--- hdl/iffifo_pkg.sv
// Bus word types, register map offsets, FIFO depths and STATUS/FLAGS field positions
package iffifo_pkg;

  // Register bus geometry
  localparam int ADDR_W  = 5;
  localparam int DATA_W  = 32;
  localparam int BE_W    = DATA_W / 8;
  // Fill count must reach the depth itself, so one bit more than the pointer
  localparam int LEVEL_W = 4;

  // Byte address inside the 32-byte peripheral block
  typedef logic [ADDR_W-1:0]  addr_t;
  // Bus and stream data word
  typedef logic [DATA_W-1:0]  data_t;
  // Byte enables, one per data byte
  typedef logic [BE_W-1:0]    be_t;
  // FIFO fill count, 0 up to the depth
  typedef logic [LEVEL_W-1:0] level_t;

  // FIFO depths, powers of two
  localparam int TX_DEPTH = 4;
  localparam int RX_DEPTH = 4;

  // Transmit FIFO entry holds the byte enables above the data word
  localparam int TX_FIFO_W = DATA_W + BE_W;
  localparam int RX_FIFO_W = DATA_W;

  // Register file offsets
  localparam addr_t STATUS_OFFSET   = 5'h00;
  localparam addr_t FLAGS_OFFSET    = 5'h04;

  // Window offsets
  localparam addr_t FIFO_IN_OFFSET  = 5'h10;
  localparam addr_t FIFO_OUT_OFFSET = 5'h14;

  // Window range, 0x10 up to 0x17 inclusive
  localparam addr_t WIN_BASE        = 5'h10;
  localparam addr_t WIN_LAST        = 5'h17;

  // STATUS fields
  localparam int STATUS_TX_LEVEL_LSB = 0;
  localparam int STATUS_RX_LEVEL_LSB = 4;
  localparam int STATUS_TX_FULL_BIT  = 8;
  localparam int STATUS_TX_EMPTY_BIT = 9;
  localparam int STATUS_RX_FULL_BIT  = 10;
  localparam int STATUS_RX_EMPTY_BIT = 11;

  // FLAGS fields, sticky and write-one-to-clear
  localparam int FLAGS_TX_OVERFLOW_BIT  = 0;
  localparam int FLAGS_RX_UNDERFLOW_BIT = 1;

endpackage

//--- hdl/iffifo_regs.sv
// STATUS and sticky FLAGS register file with write-one-to-clear
`timescale 1ns/1ns

module iffifo_regs (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                valid_i,
  input  logic                write_i,
  input  iffifo_pkg::addr_t   addr_i,
  input  iffifo_pkg::data_t   wdata_i,
  input  iffifo_pkg::level_t  tx_level_i,
  input  iffifo_pkg::level_t  rx_level_i,
  input  logic                tx_full_i,
  input  logic                tx_empty_i,
  input  logic                rx_full_i,
  input  logic                rx_empty_i,
  input  logic                tx_overflow_i,
  input  logic                rx_underflow_i,
  output iffifo_pkg::data_t   rdata_o,
  output logic                error_o
);

  import iffifo_pkg::*;

  // Sticky flags
  logic tx_overflow_q;
  logic rx_underflow_q;

  // Offset decode
  logic hit_status;
  logic hit_flags;
  logic rd_ok;
  logic wr_ok;
  logic flags_wr;

  // Assembled register images
  data_t status;
  data_t flags;

  always_comb begin
    hit_status = (addr_i == STATUS_OFFSET);
    hit_flags  = (addr_i == FLAGS_OFFSET);
    // STATUS and FLAGS read, only FLAGS takes writes
    rd_ok      = hit_status | hit_flags;
    wr_ok      = hit_flags;
    flags_wr   = valid_i & write_i & hit_flags;
  end

  // Live FIFO state, unused bits stay zero
  always_comb begin
    status = '0;
    status[STATUS_TX_LEVEL_LSB +: LEVEL_W] = tx_level_i;
    status[STATUS_RX_LEVEL_LSB +: LEVEL_W] = rx_level_i;
    status[STATUS_TX_FULL_BIT]             = tx_full_i;
    status[STATUS_TX_EMPTY_BIT]            = tx_empty_i;
    status[STATUS_RX_FULL_BIT]             = rx_full_i;
    status[STATUS_RX_EMPTY_BIT]            = rx_empty_i;

    flags = '0;
    flags[FLAGS_TX_OVERFLOW_BIT]  = tx_overflow_q;
    flags[FLAGS_RX_UNDERFLOW_BIT] = rx_underflow_q;
  end

  // Read mux and error
  always_comb begin
    rdata_o = '0;
    error_o = 1'b0;
    if (valid_i) begin
      if (write_i) begin
        error_o = ~wr_ok;
      end else begin
        error_o = ~rd_ok;
        if (hit_status) begin
          rdata_o = status;
        end else if (hit_flags) begin
          rdata_o = flags;
        end
      end
    end
  end

  // A new event wins over a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tx_overflow_q  <= 1'b0;
      rx_underflow_q <= 1'b0;
    end else begin
      if (tx_overflow_i) begin
        tx_overflow_q <= 1'b1;
      end else if (flags_wr && wdata_i[FLAGS_TX_OVERFLOW_BIT]) begin
        tx_overflow_q <= 1'b0;
      end
      if (rx_underflow_i) begin
        rx_underflow_q <= 1'b1;
      end else if (flags_wr && wdata_i[FLAGS_RX_UNDERFLOW_BIT]) begin
        rx_underflow_q <= 1'b0;
      end
    end
  end

endmodule

//--- hdl/iffifo_top.sv
// iffifo peripheral top with bus demux, window, register file and two FIFOs
`timescale 1ns/1ns

module iffifo_top (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               reg_valid_i,
  input  logic               reg_write_i,
  input  iffifo_pkg::addr_t  reg_addr_i,
  input  iffifo_pkg::data_t  reg_wdata_i,
  input  iffifo_pkg::be_t    reg_wstrb_i,
  output iffifo_pkg::data_t  reg_rdata_o,
  output logic               reg_error_o,
  output iffifo_pkg::data_t  tx_data_o,
  output iffifo_pkg::be_t    tx_be_o,
  output logic               tx_valid_o,
  input  logic               tx_ready_i,
  input  iffifo_pkg::data_t  rx_data_i,
  input  logic               rx_valid_i,
  output logic               rx_ready_o
);

  import iffifo_pkg::*;

  // Demux to targets
  logic regs_valid;
  logic tx_win_valid;
  logic rx_win_valid;
  data_t regs_rdata;
  data_t win_rdata;
  logic regs_error;
  logic win_error;

  // Window to FIFOs
  logic tx_push;
  data_t tx_push_data;
  be_t tx_push_be;
  logic rx_pop;

  // FIFO state
  logic [TX_FIFO_W-1:0] tx_head;
  data_t rx_head;
  logic tx_full;
  logic tx_empty;
  logic rx_full;
  logic rx_empty;
  level_t tx_level;
  level_t rx_level;
  logic tx_overflow;
  logic rx_underflow;

  // Stream handshakes
  logic tx_xfer;
  logic rx_xfer;

  assign tx_valid_o = ~tx_empty;
  assign tx_xfer = tx_valid_o & tx_ready_i;
  // Head entry holds until the transfer pops it
  assign {tx_be_o, tx_data_o} = tx_head;

  assign rx_ready_o = ~rx_full;
  assign rx_xfer = rx_valid_i & rx_ready_o;

  iffifo_bus_demux demux (
    .reg_valid_i   (reg_valid_i),   .reg_write_i    (reg_write_i),
    .reg_addr_i    (reg_addr_i),    .regs_rdata_i   (regs_rdata),
    .win_rdata_i   (win_rdata),     .regs_error_i   (regs_error),
    .win_error_i   (win_error),     .regs_valid_o   (regs_valid),
    .tx_win_valid_o(tx_win_valid),  .rx_win_valid_o (rx_win_valid),
    .reg_rdata_o   (reg_rdata_o),   .reg_error_o    (reg_error_o)
  );

  iffifo_window window (
    .tx_win_valid_i(tx_win_valid), .rx_win_valid_i(rx_win_valid),
    .addr_i        (reg_addr_i),   .wdata_i       (reg_wdata_i),
    .wstrb_i       (reg_wstrb_i),  .rx_head_i     (rx_head),
    .rx_empty_i    (rx_empty),     .tx_push_o     (tx_push),
    .tx_data_o     (tx_push_data), .tx_be_o       (tx_push_be),
    .rx_pop_o      (rx_pop),       .rdata_o       (win_rdata),
    .error_o       (win_error)
  );

  iffifo_regs regs (
    .clk_i        (clk_i),       .rst_i         (rst_i),
    .valid_i      (regs_valid),  .write_i       (reg_write_i),
    .addr_i       (reg_addr_i),  .wdata_i       (reg_wdata_i),
    .tx_level_i   (tx_level),    .rx_level_i    (rx_level),
    .tx_full_i    (tx_full),     .tx_empty_i    (tx_empty),
    .rx_full_i    (rx_full),     .rx_empty_i    (rx_empty),
    .tx_overflow_i(tx_overflow), .rx_underflow_i(rx_underflow),
    .rdata_o      (regs_rdata),  .error_o       (regs_error)
  );

  // Pops only on a transfer, which needs valid, so it never underflows
  iffifo_fifo #(.WIDTH(TX_FIFO_W), .DEPTH(TX_DEPTH)) tx_fifo (
    .clk_i     (clk_i),   .rst_i      (rst_i),
    .push_i    (tx_push), .pop_i      (tx_xfer),
    .wdata_i   ({tx_push_be, tx_push_data}),
    .rdata_o   (tx_head), .full_o     (tx_full),
    .empty_o   (tx_empty), .level_o   (tx_level),
    .overflow_o(tx_overflow), .underflow_o()
  );

  // Pushes only while ready, so it never overflows
  iffifo_fifo #(.WIDTH(RX_FIFO_W), .DEPTH(RX_DEPTH)) rx_fifo (
    .clk_i     (clk_i),   .rst_i      (rst_i),
    .push_i    (rx_xfer), .pop_i      (rx_pop),
    .wdata_i   (rx_data_i),
    .rdata_o   (rx_head), .full_o     (rx_full),
    .empty_o   (rx_empty), .level_o   (rx_level),
    .overflow_o(),        .underflow_o(rx_underflow)
  );

endmodule

//--- hdl/iffifo_window.sv
// Transmit and receive window decode into FIFO push and pop strobes
`timescale 1ns/1ns

module iffifo_window (
  input  logic               tx_win_valid_i,
  input  logic               rx_win_valid_i,
  input  iffifo_pkg::addr_t  addr_i,
  input  iffifo_pkg::data_t  wdata_i,
  input  iffifo_pkg::be_t    wstrb_i,
  input  iffifo_pkg::data_t  rx_head_i,
  input  logic               rx_empty_i,
  output logic               tx_push_o,
  output iffifo_pkg::data_t  tx_data_o,
  output iffifo_pkg::be_t    tx_be_o,
  output logic               rx_pop_o,
  output iffifo_pkg::data_t  rdata_o,
  output logic               error_o
);

  import iffifo_pkg::*;

  // Offset matches for each direction
  logic tx_offset_ok;
  logic rx_offset_ok;

  always_comb begin
    // Only the exact data offset of each window is accepted
    tx_offset_ok = (addr_i == FIFO_IN_OFFSET);
    rx_offset_ok = (addr_i == FIFO_OUT_OFFSET);

    // Push carries the bus word and its strobes into the transmit FIFO
    tx_push_o = tx_win_valid_i & tx_offset_ok;
    tx_data_o = wdata_i;
    tx_be_o   = wstrb_i;

    // Pop on every good read, an empty FIFO reports underflow itself
    rx_pop_o  = rx_win_valid_i & rx_offset_ok;

    // Head of the receive FIFO, zero when nothing is there
    rdata_o = '0;
    if (rx_pop_o && !rx_empty_i) begin
      rdata_o = rx_head_i;
    end

    // Wrong offset or wrong direction, no strobe goes out
    error_o = (tx_win_valid_i & ~tx_offset_ok) | (rx_win_valid_i & ~rx_offset_ok);
  end

  // The demux decodes direction one-hot, so both FIFOs never move on one access
  always_comb begin
    assert (!(tx_push_o && rx_pop_o))
      else $error("window raised push and pop in the same access");
  end

endmodule

//--- iffifo_top.f
hdl/iffifo_pkg.sv
hdl/iffifo_bus_demux.sv
hdl/iffifo_window.sv
hdl/iffifo_fifo.sv
hdl/iffifo_regs.sv
hdl/iffifo_top.sv
tests/iffifo_tb.sv

//--- run.sh
#!/bin/sh
# Build the iffifo testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module iffifo_tb -f iffifo_top.f -o iffifo_sim \
  > build.log 2>&1 \
  && ./obj_dir/iffifo_sim > sim.log 2>&1 \
  || { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

//--- tests/iffifo_tb.sv
// Table-driven testbench for iffifo_top with LFSR data, scoreboard queues and a watchdog
`timescale 1ns/1ns

module iffifo_tb;

  import iffifo_pkg::*;

  // Step kinds of the stimulus table
  typedef enum logic [2:0] {
    BUS_WR, BUS_RD, STREAM_IN, DRAIN_ONE, SET_READY
  } kind_t;

  // One row of the table
  typedef struct packed {
    kind_t      kind;
    addr_t      addr;
    data_t      data;
    be_t        be;
    logic       rnd;
    logic       predict;
    data_t      exp_data;
    logic       exp_err;
    logic [7:0] test;
  } step_t;

  // DUT ports
  logic  clk_i;
  logic  rst_i;
  logic  reg_valid_i;
  logic  reg_write_i;
  addr_t reg_addr_i;
  data_t reg_wdata_i;
  be_t   reg_wstrb_i;
  data_t reg_rdata_o;
  logic  reg_error_o;
  data_t tx_data_o;
  be_t   tx_be_o;
  logic  tx_valid_o;
  logic  tx_ready_i;
  data_t rx_data_i;
  logic  rx_valid_i;
  logic  rx_ready_o;

  // Table and scoreboard
  step_t                  steps[$];
  logic [TX_FIFO_W-1:0]   tx_q[$];
  data_t                  rx_q[$];
  logic                   tx_ovf;
  logic                   rx_unf;
  logic [31:0]            lfsr_q;
  logic                   table_ready;
  int                     err_count;
  int                     test_err_base;
  int                     tests_ok;
  int                     tests_bad;

  iffifo_top iffifo_top_i (
    .clk_i      (clk_i),       .rst_i      (rst_i),
    .reg_valid_i(reg_valid_i), .reg_write_i(reg_write_i),
    .reg_addr_i (reg_addr_i),  .reg_wdata_i(reg_wdata_i),
    .reg_wstrb_i(reg_wstrb_i), .reg_rdata_o(reg_rdata_o),
    .reg_error_o(reg_error_o), .tx_data_o  (tx_data_o),
    .tx_be_o    (tx_be_o),     .tx_valid_o (tx_valid_o),
    .tx_ready_i (tx_ready_i),  .rx_data_i  (rx_data_i),
    .rx_valid_i (rx_valid_i),  .rx_ready_o (rx_ready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic random_word(output data_t w);
    w = '0;
    for (int b = 0; b < DATA_W; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w = {w[DATA_W-2:0], lfsr_q[0]};
    end
  endtask

  task automatic add_step(input kind_t k, input addr_t a, input data_t d, input be_t b,
                          input logic r, input logic p, input data_t ed, input logic ee,
                          input logic [7:0] t);
    step_t s;
    s = '{kind: k, addr: a, data: d, be: b, rnd: r, predict: p,
          exp_data: ed, exp_err: ee, test: t};
    steps.push_back(s);
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_error(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_level(input level_t got, input level_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_be(input be_t got, input be_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  // Register map read value from the scoreboard state before the edge
  function automatic data_t predict_read(input addr_t a);
    data_t r;
    r = '0;
    if (a == STATUS_OFFSET) begin
      r[3:0] = 4'(tx_q.size());
      r[7:4] = 4'(rx_q.size());
      r[8]   = (tx_q.size() == TX_DEPTH);
      r[9]   = (tx_q.size() == 0);
      r[10]  = (rx_q.size() == RX_DEPTH);
      r[11]  = (rx_q.size() == 0);
    end else if (a == FLAGS_OFFSET) begin
      r[1:0] = {rx_unf, tx_ovf};
    end else if (a == FIFO_OUT_OFFSET && rx_q.size() != 0) begin
      r = rx_q[0];
    end
    return r;
  endfunction

  // What the coming clock edge does to the FIFOs and flags
  task automatic apply_edge(input step_t st, input data_t w, input logic ready);
    logic tx_was_full;
    logic rx_was_empty;
    tx_was_full  = (tx_q.size() == TX_DEPTH);
    rx_was_empty = (rx_q.size() == 0);
    if (ready && tx_q.size() != 0) begin
      void'(tx_q.pop_front());
    end
    if (st.kind == STREAM_IN && rx_q.size() < RX_DEPTH) begin
      rx_q.push_back(w);
    end
    if (st.kind == BUS_WR && st.addr == FIFO_IN_OFFSET) begin
      // Full is judged before the same-edge pop
      if (tx_was_full) begin
        tx_ovf = 1'b1;
      end else begin
        tx_q.push_back({st.be, w});
      end
    end
    if (st.kind == BUS_RD && st.addr == FIFO_OUT_OFFSET) begin
      if (rx_was_empty) begin
        rx_unf = 1'b1;
      end else begin
        void'(rx_q.pop_front());
      end
    end
    if (st.kind == BUS_WR && st.addr == FLAGS_OFFSET) begin
      if (w[0]) tx_ovf = 1'b0;
      if (w[1]) rx_unf = 1'b0;
    end
  endtask

  task automatic report_test(input logic [7:0] t);
    if (err_count == test_err_base) begin
      $display("test %0d ok", t);
      tests_ok++;
    end else begin
      $display("test %0d had %0d mismatches", t, err_count - test_err_base);
      tests_bad++;
    end
    test_err_base = err_count;
  endtask

  task automatic build_table();
    // kind, addr, data, be, rnd, predict, exp_data, exp_err, test
    // Transmit order and hold while ready is low
    add_step(SET_READY, 5'h00, 32'h0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b0, 8'd1);
    add_step(BUS_RD, STATUS_OFFSET, 32'h0, 4'h0, 1'b0, 1'b1, 32'h0, 1'b0, 8'd1);
    add_step(BUS_RD, FLAGS_OFFSET, 32'h0, 4'h0, 1'b0, 1'b1, 32'h0, 1'b0, 8'd1);
    add_step(BUS_WR, FIFO_IN_OFFSET, 32'h0, 4'hF, 1'b1, 1'b0, 32'h0, 1'b0, 8'd1);
    add_step(BUS_WR, FIFO_IN_OFFSET, 32'h0, 4'h3, 1'b1, 1'b0, 32'h0, 1'b0, 8'd1);
    add_step(BUS_WR, FIFO_IN_OFFSET, 32'h0, 4'hC, 1'b1, 1'b0, 32'h0, 1'b0, 8'd1);
    add_step(SET_READY, 5'h00, 32'h0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b0, 8'd1);
    add_step(DRAIN_ONE, 5'h00, 32'h0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b0, 8'd1);
    add_step(SET_READY, 5'h00, 32'h1, 4'h0, 1'b0, 1'b0, 32'h0, 1'b0, 8'd1);
    add_step(BUS_RD, STATUS_OFFSET, 32'h0, 4'h0, 1'b0, 1'b1, 32'h0, 1'b0, 8'd1);
    add_step(BUS_RD, STATUS_OFFSET, 32'h0, 4'h0, 1'b0, 1'b1, 32'h0, 1'b0, 8'd1);
    // Receive order, ready drops after four words
    for (int i = 0; i < RX_DEPTH + 1; i++) begin
      add_step(STREAM_IN, 5'h00, 32'h0, 4'h0, 1'b1, 1'b0, 32'h0, 1'b0, 8'd2);
    end
    add_step(BUS_RD, FIFO_OUT_OFFSET, 32'h0, 4'h0, 1'b0, 1'b1, 32'h0, 1'b0, 8'd2);
    add_step(BUS_RD, FIFO_OUT_OFFSET, 32'h0, 4'h0, 1'b0, 1'b1, 32'h0, 1'b0, 8'd2);
    add_step(BUS_RD, STATUS_OFFSET, 32'h0, 4'h0, 1'b0, 1'b1, 32'h0, 1'b0, 8'd2);
    add_step(BUS_RD, FIFO_OUT_OFFSET, 32'h0, 4'h0, 1'b0, 1'b1, 32'h0, 1'b0, 8'd2);
    add_step(BUS_RD, FIFO_OUT_OFFSET, 32'h0, 4'h0, 1'b0, 1'b1, 32'h0, 1'b0, 8'd2);
    // Mixed traffic with STATUS after each change
    add_step(BUS_WR, FIFO_IN_OFFSET, 32'h0, 4'h1, 1'b1, 1'b0, 32'h0, 1'b0, 8'd3);
    add_step(STREAM_IN, 5'h00, 32'h0, 4'h0, 1'b1, 1'b0, 32'h0, 1'b0, 8'd3);
    add_step(BUS_RD, STATUS_OFFSET, 32'h0, 4'h0, 1'b0, 1'b1, 32'h0, 1'b0, 8'd3);
    add_step(BUS_RD, FIFO_OUT_OFFSET, 32'h0, 4'h0, 1'b0, 1'b1, 32'h0, 1'b0, 8'd3);
    add_step(BUS_RD, STATUS_OFFSET, 32'h0, 4'h0, 1'b0, 1'b1, 32'h0, 1'b0, 8'd3);
    // Overflow, underflow and write-one-to-clear
    add_step(SET_READY, 5'h00, 32'h0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b0, 8'd4);
    for (int i = 0; i < TX_DEPTH + 1; i++) begin
      add_step(BUS_WR, FIFO_IN_OFFSET, 32'h0, be_t'(i + 6), 1'b1, 1'b0, 32'h0, 1'b0, 8'd4);
    end
    add_step(BUS_RD, FLAGS_OFFSET, 32'h0, 4'h0, 1'b0, 1'b1, 32'h0, 1'b0, 8'd4);
    add_step(BUS_RD, FIFO_OUT_OFFSET, 32'h0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b0, 8'd4);
    add_step(BUS_RD, FLAGS_OFFSET, 32'h0, 4'h0, 1'b0, 1'b1, 32'h0, 1'b0, 8'd4);
    add_step(BUS_WR, FLAGS_OFFSET, 32'h3, 4'hF, 1'b0, 1'b0, 32'h0, 1'b0, 8'd4);
    add_step(BUS_RD, FLAGS_OFFSET, 32'h0, 4'h0, 1'b0, 1'b1, 32'h0, 1'b0, 8'd4);
    for (int i = 0; i < TX_DEPTH; i++) begin
      add_step(DRAIN_ONE, 5'h00, 32'h0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b0, 8'd4);
    end
    add_step(BUS_RD, STATUS_OFFSET, 32'h0, 4'h0, 1'b0, 1'b1, 32'h0, 1'b0, 8'd4);
    // Illegal accesses leave both levels alone
    add_step(STREAM_IN, 5'h00, 32'h0, 4'h0, 1'b1, 1'b0, 32'h0, 1'b0, 8'd5);
    add_step(BUS_WR, FIFO_IN_OFFSET, 32'h0, 4'h9, 1'b1, 1'b0, 32'h0, 1'b0, 8'd5);
    add_step(BUS_RD, FIFO_IN_OFFSET, 32'h0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b1, 8'd5);
    add_step(BUS_WR, FIFO_OUT_OFFSET, 32'h0, 4'hF, 1'b1, 1'b0, 32'h0, 1'b1, 8'd5);
    add_step(BUS_WR, STATUS_OFFSET, 32'hFFF, 4'hF, 1'b0, 1'b0, 32'h0, 1'b1, 8'd5);
    add_step(BUS_RD, 5'h18, 32'h0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b1, 8'd5);
    add_step(BUS_WR, 5'h18, 32'h0, 4'hF, 1'b1, 1'b0, 32'h0, 1'b1, 8'd5);
    add_step(BUS_RD, 5'h08, 32'h0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b1, 8'd5);
    add_step(BUS_RD, STATUS_OFFSET, 32'h0, 4'h0, 1'b0, 1'b1, 32'h0, 1'b0, 8'd5);
    add_step(DRAIN_ONE, 5'h00, 32'h0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b0, 8'd5);
    add_step(BUS_RD, FIFO_OUT_OFFSET, 32'h0, 4'h0, 1'b0, 1'b1, 32'h0, 1'b0, 8'd5);
  endtask

  // Bounded by the table length
  initial begin
    wait (table_ready === 1'b1);
    repeat (steps.size() * 20) @(posedge clk_i);
    $display("run timed out after %0d cycles without finishing the table", steps.size() * 20);
    $display("test failed");
    $finish;
  end

  initial begin
    step_t      st;
    data_t      wdata;
    data_t      exp_rd;
    logic [7:0] cur_test;
    logic       ready_level;
    logic       ready_now;
    rst_i       = 1'b1;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    reg_wstrb_i = '0;
    tx_ready_i  = 1'b0;
    rx_data_i   = '0;
    rx_valid_i  = 1'b0;
    tx_ovf      = 1'b0;
    rx_unf      = 1'b0;
    lfsr_q      = 32'd26;
    err_count     = 0;
    test_err_base = 0;
    tests_ok      = 0;
    tests_bad     = 0;
    ready_level   = 1'b0;
    table_ready   = 1'b0;
    build_table();
    table_ready = 1'b1;
    cur_test    = steps[0].test;

    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    for (int i = 0; i < steps.size(); i++) begin
      st = steps[i];
      if (st.test != cur_test) begin
        report_test(cur_test);
        cur_test = st.test;
      end
      wdata = st.data;
      if (st.rnd) begin
        random_word(wdata);
      end
      if (st.kind == SET_READY) begin
        ready_level = st.data[0];
      end
      ready_now = ready_level | (st.kind == DRAIN_ONE);

      @(posedge clk_i);
      reg_valid_i <= (st.kind == BUS_WR) || (st.kind == BUS_RD);
      reg_write_i <= (st.kind == BUS_WR);
      reg_addr_i  <= st.addr;
      reg_wdata_i <= wdata;
      reg_wstrb_i <= st.be;
      rx_valid_i  <= (st.kind == STREAM_IN);
      rx_data_i   <= wdata;
      tx_ready_i  <= ready_now;

      // Combinational responses have settled by the falling edge
      @(negedge clk_i);
      check_error(tx_valid_o, tx_q.size() != 0, "tx_valid_o");
      if (tx_q.size() != 0) begin
        check_data(tx_data_o, tx_q[0][DATA_W-1:0], "tx_data_o");
        check_be(tx_be_o, tx_q[0][TX_FIFO_W-1:DATA_W], "tx_be_o");
      end
      check_error(rx_ready_o, rx_q.size() < RX_DEPTH, "rx_ready_o");
      if (st.kind == BUS_RD) begin
        exp_rd = st.predict ? predict_read(st.addr) : st.exp_data;
        check_data(reg_rdata_o, exp_rd, "reg_rdata_o");
        if (st.addr == STATUS_OFFSET) begin
          check_level(reg_rdata_o[3:0], 4'(tx_q.size()), "STATUS tx_level");
          check_level(reg_rdata_o[7:4], 4'(rx_q.size()), "STATUS rx_level");
        end
      end
      if (st.kind == BUS_WR || st.kind == BUS_RD) begin
        check_error(reg_error_o, st.exp_err, "reg_error_o");
      end
      apply_edge(st, wdata, ready_now);
    end

    @(posedge clk_i);
    reg_valid_i <= 1'b0;
    rx_valid_i  <= 1'b0;
    report_test(cur_test);
    $display("%0d tests ok, %0d tests with mismatches, %0d mismatches in total",
             tests_ok, tests_bad, err_count);
    if (tests_bad == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
